/* rtl/pkt_defines.svh */
/*
 * Packetizer build constants
 * FIFO depth, payload length and display address,
 * plus the fixed UDP header fields of the sample stream
 */

`ifndef PKT_DEFINES_SVH
`define PKT_DEFINES_SVH

// Payload buffering
`define PKT_FIFO_DEPTH     16
`define PKT_PAYLOAD_BYTES  6

// 192.168.1.100, also shown on the seven-segment digits
`define PKT_DEST_IP        32'hC0A8_0164

// Fixed UDP header fields
`define PKT_LOCAL_IP       32'hC0A8_0180
`define PKT_UDP_SRC_PORT   16'd1234
`define PKT_UDP_DST_PORT   16'd5678
`define PKT_UDP_TTL        8'd64
`define PKT_UDP_LENGTH     16'd6
`define PKT_UDP_CHECKSUM   16'd0

`endif

/* rtl/pkt_pkg.sv */
/*
 * Shared types for the ADC packetizer
 * Payload byte, sample word, IPv4 address, segment pattern
 * and the nibble to seven-segment decoder
 */

`default_nettype none

package pkt_pkg;

    typedef logic [7:0]  byte_t;
    typedef logic [15:0] sample_t;
    typedef logic [31:0] ipv4_t;

    // Segments gfedcba, low lights the segment
    typedef logic [6:0]  seg_t;

    function automatic seg_t hex_to_seg(input logic [3:0] nibble);
        seg_t lit;
        case (nibble)
            4'h0: lit = 7'h3F;
            4'h1: lit = 7'h06;
            4'h2: lit = 7'h5B;
            4'h3: lit = 7'h4F;
            4'h4: lit = 7'h66;
            4'h5: lit = 7'h6D;
            4'h6: lit = 7'h7D;
            4'h7: lit = 7'h07;
            4'h8: lit = 7'h7F;
            4'h9: lit = 7'h6F;
            4'hA: lit = 7'h77;
            4'hB: lit = 7'h7C;
            4'hC: lit = 7'h39;
            4'hD: lit = 7'h5E;
            4'hE: lit = 7'h79;
            default: lit = 7'h71;
        endcase
        // Board digits are common anode
        return ~lit;
    endfunction

endpackage

`default_nettype wire

/* rtl/byte_stream_if.sv */
/*
 * Payload byte stream
 * Valid/ready handshake with an end-of-packet flag
 */

`timescale 1ns/1ps
`default_nettype none

interface byte_stream_if;

    pkt_pkg::byte_t data;
    logic           valid;
    logic           ready;
    // Marks the final byte of a packet
    logic           last;

    modport src (output data, output valid, output last, input ready);

    modport snk (input data, input valid, input last, output ready);

    // Passive observer, e.g. the LED register
    modport mon (input data, input valid, input last, input ready);

endinterface

`default_nettype wire

/* rtl/sample_packetizer.sv */
/*
 * ADC sample packetizer
 * Captures m, n and adc_data on adc_valid and sends them
 * as six payload bytes, high byte first, on the byte stream.
 * Strobes the UDP header when the first byte is taken
 */

`timescale 1ns/1ps
`default_nettype none

`include "pkt_defines.svh"

module sample_packetizer (
    input  logic             clk,
    input  logic             rst,
    input  logic             adc_valid,
    input  pkt_pkg::sample_t m,
    input  pkt_pkg::sample_t n,
    input  pkt_pkg::sample_t adc_data,
    output logic             udp_hdr_valid,
    byte_stream_if.src       tx
);
    import pkt_pkg::*;

    localparam int IDX_W = $clog2(`PKT_PAYLOAD_BYTES);
    localparam logic [IDX_W-1:0] LAST_IDX = IDX_W'(`PKT_PAYLOAD_BYTES - 1);

    sample_t          m_q;
    sample_t          n_q;
    sample_t          adc_q;
    byte_t            payload [`PKT_PAYLOAD_BYTES];
    logic             busy;
    logic [IDX_W-1:0] byte_idx;
    logic             xfer;

    assign xfer = tx.valid && tx.ready;

    // Idle until a sample arrives, then walk the six bytes
    always_ff @(posedge clk) begin
        if (rst) begin
            busy     <= 1'b0;
            byte_idx <= '0;
        end else if (!busy) begin
            if (adc_valid) begin
                busy     <= 1'b1;
                byte_idx <= '0;
            end
        end else if (xfer) begin
            if (byte_idx == LAST_IDX) begin
                busy <= 1'b0;
            end else begin
                byte_idx <= byte_idx + 1'b1;
            end
        end
    end

    // Sample held for the whole packet
    always_ff @(posedge clk) begin
        if (!busy && adc_valid) begin
            m_q   <= m;
            n_q   <= n;
            adc_q <= adc_data;
        end
    end

    // Wire order: m, n, adc, each high byte first
    assign payload = '{m_q[15:8], m_q[7:0], n_q[15:8], n_q[7:0], adc_q[15:8], adc_q[7:0]};

    // Index only moves on a transfer, so a stalled beat holds steady
    assign tx.data  = payload[byte_idx];
    assign tx.valid = busy;
    assign tx.last  = (byte_idx == LAST_IDX);

    // Header goes out with the first payload byte
    assign udp_hdr_valid = xfer && (byte_idx == '0);

endmodule

`default_nettype wire

/* rtl/payload_fifo.sv */
/*
 * Synchronous payload FIFO
 * Circular buffer of byte and last flag with
 * read/write pointers and an occupancy count
 */

`timescale 1ns/1ps
`default_nettype none

`include "pkt_defines.svh"

module payload_fifo #(
    parameter int DEPTH = `PKT_FIFO_DEPTH
) (
    input  logic       clk,
    input  logic       rst,
    byte_stream_if.snk wr,
    byte_stream_if.src rd
);
    import pkt_pkg::*;

    localparam int AW = $clog2(DEPTH);
    localparam logic [AW:0] FULL_COUNT = (AW + 1)'(DEPTH);
    localparam logic [AW-1:0] LAST_SLOT = AW'(DEPTH - 1);

    byte_t         mem_data [DEPTH];
    logic          mem_last [DEPTH];
    logic [AW-1:0] wr_ptr;
    logic [AW-1:0] rd_ptr;
    logic [AW:0]   count;
    logic          do_wr;
    logic          do_rd;

    // Wraps correctly for depths that are not a power of two
    function automatic logic [AW-1:0] next_ptr(input logic [AW-1:0] ptr);
        return (ptr == LAST_SLOT) ? '0 : ptr + 1'b1;
    endfunction

    assign wr.ready = (count != FULL_COUNT);
    assign rd.valid = (count != '0);

    assign do_wr = wr.valid && wr.ready;
    assign do_rd = rd.valid && rd.ready;

    always_ff @(posedge clk) begin
        if (rst) begin
            wr_ptr <= '0;
            rd_ptr <= '0;
            count  <= '0;
        end else begin
            if (do_wr) begin
                wr_ptr <= next_ptr(wr_ptr);
            end
            if (do_rd) begin
                rd_ptr <= next_ptr(rd_ptr);
            end
            // Both at once leaves the count alone
            if (do_wr && !do_rd) begin
                count <= count + 1'b1;
            end else if (do_rd && !do_wr) begin
                count <= count - 1'b1;
            end
        end
    end

    always_ff @(posedge clk) begin
        if (do_wr) begin
            mem_data[wr_ptr] <= wr.data;
            mem_last[wr_ptr] <= wr.last;
        end
    end

    assign rd.data = mem_data[rd_ptr];
    assign rd.last = mem_last[rd_ptr];

endmodule

`default_nettype wire

/* rtl/board_display.sv */
/*
 * Board indicators
 * Green LEDs show the first byte of each outgoing packet,
 * eight inverted digits show the latched destination IPv4 address
 */

`timescale 1ns/1ps
`default_nettype none

`include "pkt_defines.svh"

module board_display (
    input  logic          clk,
    input  logic          rst,
    input  logic          udp_hdr_valid,
    byte_stream_if.mon    mon,
    output pkt_pkg::byte_t ledg,
    output pkt_pkg::seg_t hex0,
    output pkt_pkg::seg_t hex1,
    output pkt_pkg::seg_t hex2,
    output pkt_pkg::seg_t hex3,
    output pkt_pkg::seg_t hex4,
    output pkt_pkg::seg_t hex5,
    output pkt_pkg::seg_t hex6,
    output pkt_pkg::seg_t hex7
);
    import pkt_pkg::*;

    logic  first_beat;
    ipv4_t dest_ip_q;
    seg_t  digits [8];

    // Next transfer opens a packet after reset or after a last beat
    always_ff @(posedge clk) begin
        if (rst) begin
            first_beat <= 1'b1;
            ledg       <= '0;
        end else if (mon.valid && mon.ready) begin
            if (first_beat) begin
                ledg <= mon.data;
            end
            first_beat <= mon.last;
        end
    end

    always_ff @(posedge clk) begin
        if (rst) begin
            dest_ip_q <= '0;
        end else if (udp_hdr_valid) begin
            dest_ip_q <= `PKT_DEST_IP;
        end
    end

    // Digit i shows nibble i, hex0 is the lowest
    for (genvar i = 0; i < 8; i++) begin : g_digit
        assign digits[i] = hex_to_seg(dest_ip_q[4*i +: 4]);
    end

    assign hex0 = digits[0];
    assign hex1 = digits[1];
    assign hex2 = digits[2];
    assign hex3 = digits[3];
    assign hex4 = digits[4];
    assign hex5 = digits[5];
    assign hex6 = digits[6];
    assign hex7 = digits[7];

endmodule

`default_nettype wire

/* rtl/adc_udp_top.sv */
/*
 * ADC to UDP payload top level
 * Packetizer feeding the payload FIFO, FIFO output on plain
 * stream ports, LED and seven-segment display
 */

`timescale 1ns/1ps
`default_nettype none

module adc_udp_top (
    input  logic             clk,
    input  logic             rst,
    input  logic             adc_valid,
    input  pkt_pkg::sample_t m,
    input  pkt_pkg::sample_t n,
    input  pkt_pkg::sample_t adc_data,
    output logic             udp_hdr_valid,
    output pkt_pkg::byte_t   payload_data,
    output logic             payload_valid,
    input  logic             payload_ready,
    output logic             payload_last,
    output pkt_pkg::byte_t   ledg,
    output pkt_pkg::seg_t    hex0,
    output pkt_pkg::seg_t    hex1,
    output pkt_pkg::seg_t    hex2,
    output pkt_pkg::seg_t    hex3,
    output pkt_pkg::seg_t    hex4,
    output pkt_pkg::seg_t    hex5,
    output pkt_pkg::seg_t    hex6,
    output pkt_pkg::seg_t    hex7
);
    import pkt_pkg::*;

    // Packetizer to FIFO, and FIFO to the outside
    byte_stream_if pkt_stream ();
    byte_stream_if out_stream ();

    sample_packetizer packetizer_i (
        .clk           (clk),
        .rst           (rst),
        .adc_valid     (adc_valid),
        .m             (m),
        .n             (n),
        .adc_data      (adc_data),
        .udp_hdr_valid (udp_hdr_valid),
        .tx            (pkt_stream.src)
    );

    payload_fifo fifo_i (
        .clk (clk),
        .rst (rst),
        .wr  (pkt_stream.snk),
        .rd  (out_stream.src)
    );

    assign payload_data     = out_stream.data;
    assign payload_valid    = out_stream.valid;
    assign payload_last     = out_stream.last;
    assign out_stream.ready = payload_ready;

    board_display display_i (
        .clk           (clk),
        .rst           (rst),
        .udp_hdr_valid (udp_hdr_valid),
        .mon           (out_stream.mon),
        .ledg          (ledg),
        .hex0          (hex0),
        .hex1          (hex1),
        .hex2          (hex2),
        .hex3          (hex3),
        .hex4          (hex4),
        .hex5          (hex5),
        .hex6          (hex6),
        .hex7          (hex7)
    );

endmodule

`default_nettype wire

/* bench/adc_udp_properties.sv */
/*
 * Stream and header assertions for the ADC packetizer top level,
 * attached with bind
 */

`timescale 1ns/1ps
`default_nettype none

module adc_udp_properties (
    input wire logic           clk,
    input wire logic           rst,
    input wire pkt_pkg::byte_t payload_data,
    input wire logic           payload_valid,
    input wire logic           payload_ready,
    input wire logic           payload_last,
    input wire logic           udp_hdr_valid
);
    int unsigned assert_fails = 0;

    // Stalled beat must hold until taken
    stall_hold: assert property (@(posedge clk) disable iff (rst)
        payload_valid && !payload_ready |=>
            payload_valid && $stable(payload_data) && $stable(payload_last))
    else begin
        assert_fails++;
        $error("payload beat changed while stalled");
    end

    hdr_single: assert property (@(posedge clk) disable iff (rst)
        udp_hdr_valid |=> !udp_hdr_valid)
    else begin
        assert_fails++;
        $error("udp_hdr_valid high for two cycles");
    end

endmodule

bind adc_udp_top adc_udp_properties props_i (
    .clk           (clk),
    .rst           (rst),
    .payload_data  (payload_data),
    .payload_valid (payload_valid),
    .payload_ready (payload_ready),
    .payload_last  (payload_last),
    .udp_hdr_valid (udp_hdr_valid)
);

`default_nettype wire

/* bench/adc_udp_tb.sv */
/*
 * Testbench for adc_udp_top
 * Golden-file stimulus, output monitor, LED and digit checks,
 * random back-pressure phase and a watchdog
 */

`timescale 1ns/1ps
`default_nettype none

module adc_udp_tb;
    import pkt_pkg::*;

    localparam int MAX_PKTS    = 32;
    localparam int DIRECT_PKTS = 4;
    localparam int RANDOM_PKTS = 4;
    // Inverted gfedcba patterns for 0 and the digits of C0A80164
    localparam seg_t SEG_0 = 7'h40;
    localparam seg_t SEG_1 = 7'h79;
    localparam seg_t SEG_4 = 7'h19;
    localparam seg_t SEG_6 = 7'h02;
    localparam seg_t SEG_8 = 7'h00;
    localparam seg_t SEG_A = 7'h08;
    localparam seg_t SEG_C = 7'h46;

    logic    clk;
    logic    rst;
    logic    adc_valid;
    sample_t m;
    sample_t n;
    sample_t adc_data;
    logic    udp_hdr_valid;
    byte_t   payload_data;
    logic    payload_valid;
    logic    payload_ready;
    logic    payload_last;
    byte_t   ledg;
    seg_t    hex0, hex1, hex2, hex3, hex4, hex5, hex6, hex7;

    sample_t    gold_m [MAX_PKTS];
    sample_t    gold_n [MAX_PKTS];
    sample_t    gold_adc [MAX_PKTS];
    byte_t      gold_bytes [MAX_PKTS][6];
    int         num_pkts = 0;
    logic       loaded = 1'b0;
    logic [8:0] rx_q [$];
    byte_t      exp_led_q [$];
    int         rx_count = 0;
    int         expected_rx = 0;
    int         hdr_count = 0;
    int         errors = 0;
    int         checks = 0;
    logic       random_ready = 1'b0;
    integer     seed = 32'h5801_1897;
    logic       first_beat;
    logic       led_pending;
    byte_t      led_exp;

    adc_udp_top dut_i (
        .clk (clk), .rst (rst), .adc_valid (adc_valid),
        .m (m), .n (n), .adc_data (adc_data),
        .udp_hdr_valid (udp_hdr_valid),
        .payload_data (payload_data), .payload_valid (payload_valid),
        .payload_ready (payload_ready), .payload_last (payload_last),
        .ledg (ledg),
        .hex0 (hex0), .hex1 (hex1), .hex2 (hex2), .hex3 (hex3),
        .hex4 (hex4), .hex5 (hex5), .hex6 (hex6), .hex7 (hex7)
    );

    initial begin
        clk = 1'b0;
        forever #4 clk = ~clk;
    end

    task automatic check_byte(input string name, input byte_t got, input byte_t exp);
        checks++;
        if (got !== exp) begin
            errors++;
            $display("ERROR t=%0t %s: got %h expected %h", $time, name, got, exp);
        end
    endtask

    task automatic check_seg(input string name, input seg_t got, input seg_t exp);
        checks++;
        if (got !== exp) begin
            errors++;
            $display("ERROR t=%0t %s: got %h expected %h", $time, name, got, exp);
        end
    endtask

    task automatic check_flag(input string name, input logic got, input logic exp);
        checks++;
        if (got !== exp) begin
            errors++;
            $display("ERROR t=%0t %s: got %b expected %b", $time, name, got, exp);
        end
    endtask

    task automatic check_digits(input seg_t e7, input seg_t e6, input seg_t e5,
                                input seg_t e4, input seg_t e3, input seg_t e2,
                                input seg_t e1, input seg_t e0);
        check_seg("hex7", hex7, e7);
        check_seg("hex6", hex6, e6);
        check_seg("hex5", hex5, e5);
        check_seg("hex4", hex4, e4);
        check_seg("hex3", hex3, e3);
        check_seg("hex2", hex2, e2);
        check_seg("hex1", hex1, e1);
        check_seg("hex0", hex0, e0);
    endtask

    task automatic load_golden();
        int    fd;
        int    cnt;
        string line;
        logic [15:0] v [9];
        fd = $fopen("bench/adc_udp_golden.txt", "r");
        if (fd == 0) begin
            errors++;
            $display("Could not open the golden file bench/adc_udp_golden.txt");
            return;
        end
        while (!$feof(fd) && num_pkts < MAX_PKTS) begin
            line = "";
            void'($fgets(line, fd));
            if (line.len() == 0 || line[0] == "#") begin
                continue;
            end
            cnt = $sscanf(line, "%h %h %h %h %h %h %h %h %h",
                          v[0], v[1], v[2], v[3], v[4], v[5], v[6], v[7], v[8]);
            if (cnt == 9) begin
                gold_m[num_pkts]   = v[0];
                gold_n[num_pkts]   = v[1];
                gold_adc[num_pkts] = v[2];
                for (int i = 0; i < 6; i++) begin
                    gold_bytes[num_pkts][i] = v[3+i][7:0];
                end
                num_pkts++;
            end
        end
        $fclose(fd);
    endtask

    // One adc_valid pulse and an optional second one the DUT must ignore
    task automatic send_sample(input int p, input logic extra_pulse);
        @(posedge clk);
        adc_valid <= 1'b1;
        m         <= gold_m[p];
        n         <= gold_n[p];
        adc_data  <= gold_adc[p];
        exp_led_q.push_back(gold_bytes[p][0]);
        @(posedge clk);
        if (extra_pulse) begin
            m        <= ~gold_m[p];
            n        <= ~gold_n[p];
            adc_data <= ~gold_adc[p];
            @(posedge clk);
        end
        adc_valid <= 1'b0;
    endtask

    task automatic receive_packet(input int p);
        logic [8:0] beat;
        expected_rx += 6;
        while (rx_count < expected_rx) begin
            @(posedge clk);
        end
        for (int i = 0; i < 6; i++) begin
            beat = rx_q.pop_front();
            check_byte("payload_data", beat[7:0], gold_bytes[p][i]);
            check_flag("payload_last", beat[8], (i == 5));
        end
        // One header strobe per packet so far
        if (hdr_count != p + 1) begin
            errors++;
            $display("Saw %0d header strobes by the end of packet %0d where %0d were due",
                     hdr_count, p, p + 1);
        end
    endtask

    // Output monitor with the delayed LED check
    always @(posedge clk) begin
        if (rst) begin
            first_beat  = 1'b1;
            led_pending = 1'b0;
        end else begin
            if (led_pending) begin
                check_byte("ledg", ledg, led_exp);
                led_pending = 1'b0;
            end
            if (udp_hdr_valid) begin
                hdr_count++;
            end
            if (payload_valid && payload_ready) begin
                rx_q.push_back({payload_last, payload_data});
                rx_count++;
                if (first_beat) begin
                    if (exp_led_q.size() == 0) begin
                        errors++;
                        $display("Packet started at t=%0t with no sample sent", $time);
                    end else begin
                        led_exp     = exp_led_q.pop_front();
                        led_pending = 1'b1;
                    end
                end
                first_beat = payload_last;
            end
        end
    end

    // Random back-pressure only during the middle phase
    always @(posedge clk) begin
        if (!rst) begin
            payload_ready <= random_ready ? $random(seed) & 1 : 1'b1;
        end
    end

    initial begin
        wait (loaded);
        repeat (num_pkts * 200 + 100) @(posedge clk);
        $display("Timeout: the run did not finish in the allotted cycles");
        $display("RESULT: FAIL");
        $finish;
    end

    initial begin
        rst           = 1'b1;
        adc_valid     = 1'b0;
        m             = '0;
        n             = '0;
        adc_data      = '0;
        payload_ready = 1'b1;
        load_golden();
        if (num_pkts == 0) begin
            errors++;
            $display("The golden file holds no packets");
        end
        loaded = 1'b1;
        repeat (2) @(posedge clk);
        rst <= 1'b0;
        @(posedge clk);
        check_flag("payload_valid", payload_valid, 1'b0);
        check_flag("udp_hdr_valid", udp_hdr_valid, 1'b0);
        check_byte("ledg", ledg, 8'h00);
        check_digits(SEG_0, SEG_0, SEG_0, SEG_0, SEG_0, SEG_0, SEG_0, SEG_0);

        for (int p = 0; p < num_pkts; p++) begin
            random_ready <= (p >= DIRECT_PKTS) && (p < DIRECT_PKTS + RANDOM_PKTS);
            send_sample(p, (p >= DIRECT_PKTS + RANDOM_PKTS));
            receive_packet(p);
            if (p == 0) begin
                check_digits(SEG_C, SEG_0, SEG_A, SEG_8, SEG_0, SEG_1, SEG_6, SEG_4);
            end
        end
        random_ready <= 1'b0;

        // Nothing may follow the last packet
        repeat (20) @(posedge clk);
        if (rx_count != expected_rx) begin
            errors++;
            $display("Saw %0d payload beats where %0d were due", rx_count, expected_rx);
        end
        if (hdr_count != num_pkts) begin
            errors++;
            $display("Saw %0d header strobes for %0d packets", hdr_count, num_pkts);
        end

        $display("Checks: %0d, check errors: %0d, assertion failures: %0d",
                 checks, errors, dut_i.props_i.assert_fails);
        if (errors == 0 && dut_i.props_i.assert_fails == 0) begin
            $display("RESULT: PASS");
        end else begin
            $display("RESULT: FAIL");
        end
        $finish;
    end

endmodule

`default_nettype wire

/* adc_udp_top.f */
+incdir+rtl
rtl/pkt_pkg.sv
rtl/byte_stream_if.sv
rtl/sample_packetizer.sv
rtl/payload_fifo.sv
rtl/board_display.sv
rtl/adc_udp_top.sv
bench/adc_udp_properties.sv
bench/adc_udp_tb.sv

/* bench/adc_udp_golden.txt */
# m n adc_data, then the six payload bytes in wire order
# (m hi, m lo, n hi, n lo, adc hi, adc lo), all hex
1234 5678 9ABC 12 34 56 78 9A BC
0000 0000 0000 00 00 00 00 00 00
FFFF 0001 8000 FF FF 00 01 80 00
A5A5 5A5A 0F0F A5 A5 5A 5A 0F 0F
0102 0304 0506 01 02 03 04 05 06
DEAD BEEF CAFE DE AD BE EF CA FE
7F80 8001 00FF 7F 80 80 01 00 FF
1357 2468 ACE0 13 57 24 68 AC E0
C0A8 0164 3FF0 C0 A8 01 64 3F F0
4321 8765 0BAD 43 21 87 65 0B AD
